// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cache
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with $(SIM), run it, look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -o $(TOP) -f $(FILELIST)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cpu_req_t   cpu_req,
    output word_t      cpu_rdata,
    output logic       cpu_resp,
    output mem_req_t   mem_req,
    input  line_t      mem_rdata,
    input  logic       mem_resp,
    output set_idx_t   set_idx,
    output way_write_t way_wr [`CACHE_WAYS],
    input  logic       hit,
    input  way_idx_t   hit_way,
    input  way_idx_t   victim_way,
    input  way_entry_t victim,
    input  word_t      read_word,
    input  line_t      merged_line,
    output logic       plru_update,
    output way_idx_t   plru_way
);

    cache_state_t state;
    cache_state_t state_next;
    logic         pending;
    logic         is_read;
    logic         is_write;
    logic         lookup_hit;
    line_mask_t   word_mask;
    addr_u        victim_addr;
    addr_u        fill_addr;

    assign is_read    = cpu_req.rmask != '0;
    assign is_write   = cpu_req.wmask != '0;
    assign pending    = is_read || is_write;
    assign set_idx    = cpu_req.addr.f.set_idx;
    assign lookup_hit = (state == lookup) && hit;

    // four byte lanes at the request offset
    assign word_mask = line_mask_t'(byte_mask_t'('1)) << cpu_req.addr.f.offset;

    // line-aligned addresses for write-back and refill
    assign victim_addr.f = '{tag: victim.tag, set_idx: set_idx, offset: '0};
    assign fill_addr.f   = '{tag: cpu_req.addr.f.tag, set_idx: set_idx, offset: '0};

    always_comb begin
        state_next = state;
        case (state)
            // hold off while the previous response is still visible
            idle: if (pending && !cpu_resp) state_next = lookup;
            lookup: begin
                if (hit) begin
                    state_next = idle;
                end else if (victim.valid && victim.dirty) begin
                    state_next = write_back;
                end else begin
                    state_next = allocate;
                end
            end
            write_back: if (mem_resp) state_next = allocate;
            allocate: if (mem_resp) state_next = idle;
            default: state_next = idle;
        endcase
    end

    always_comb begin
        mem_req       = '0;
        mem_req.addr  = fill_addr.raw;
        mem_req.wdata = victim.line;
        if (state == write_back) begin
            mem_req.write = 1'b1;
            mem_req.addr  = victim_addr.raw;
        end else if (state == allocate) begin
            mem_req.read = 1'b1;
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_wr[w] = '0;
        end
        if (lookup_hit && is_write) begin
            way_wr[hit_way] = '{we: 1'b1, mask: word_mask, line: merged_line,
                                tag: cpu_req.addr.f.tag, valid: 1'b1, dirty: 1'b1};
        end
        // refill lands clean in the victim way
        if ((state == allocate) && mem_resp) begin
            way_wr[victim_way] = '{we: 1'b1, mask: '1, line: mem_rdata,
                                   tag: cpu_req.addr.f.tag, valid: 1'b1, dirty: 1'b0};
        end
    end

    assign plru_update = lookup_hit;
    assign plru_way    = hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            cpu_resp <= 1'b0;
        end else begin
            state    <= state_next;
            cpu_resp <= lookup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit && is_read) begin
            cpu_rdata <= read_word;
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write));

    a_req_legal: assert property (@(posedge clk) disable iff (rst)
        pending |-> !(is_read && is_write));

    // memory sees a stable request until it answers
    a_strobe_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) && !mem_resp |=>
            $stable(mem_req.addr) && (mem_req.read || mem_req.write));

endmodule

// ==== rtl/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16
`define LINE_BYTES 32

// processor word width and way index width
`define WORD_W 32
`define WAY_W 2

// address split: tag | set | byte offset
`define ADDR_W 32
`define OFFSET_W 5
`define SET_W 4
`define TAG_W 23

`endif

// ==== rtl/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0]       word_t;
    typedef logic [8*`LINE_BYTES-1:0] line_t;
    typedef logic [`WORD_W/8-1:0]     byte_mask_t;
    typedef logic [`LINE_BYTES-1:0]   line_mask_t;
    typedef logic [`TAG_W-1:0]        tag_t;
    typedef logic [`SET_W-1:0]        set_idx_t;
    typedef logic [`WAY_W-1:0]        way_idx_t;
    typedef logic [2:0]               plru_bits_t;

    typedef struct packed {
        tag_t                 tag;
        set_idx_t             set_idx;
        logic [`OFFSET_W-1:0] offset;
    } addr_fields_t;

    // raw view goes to memory, field view drives indexing
    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        addr_fields_t       f;
    } addr_u;

    typedef struct packed {
        addr_u      addr;
        byte_mask_t rmask;
        byte_mask_t wmask;
        word_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic               read;
        logic               write;
        line_t              wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_entry_t;

    typedef struct packed {
        logic       we;
        line_mask_t mask;
        line_t      line;
        tag_t       tag;
        logic       valid;
        logic       dirty;
    } way_write_t;

    typedef enum logic [1:0] {
        idle,
        lookup,
        write_back,
        allocate
    } cache_state_t;

endpackage

// ==== rtl/cache_top.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    output word_t    cpu_rdata,
    output logic     cpu_resp,
    output mem_req_t mem_req,
    input  line_t    mem_rdata,
    input  logic     mem_resp
);

    set_idx_t   set_idx;
    way_write_t way_wr  [`CACHE_WAYS];
    way_entry_t entries [`CACHE_WAYS];
    logic       hit;
    way_idx_t   hit_way;
    way_idx_t   victim_way;
    way_entry_t victim;
    word_t      read_word;
    line_t      merged_line;
    logic       plru_update;
    way_idx_t   plru_way;

    cache_ctrl ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_rdata   (cpu_rdata),
        .cpu_resp    (cpu_resp),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .set_idx     (set_idx),
        .way_wr      (way_wr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim      (victim),
        .read_word   (read_word),
        .merged_line (merged_line),
        .plru_update (plru_update),
        .plru_way    (plru_way)
    );

    // one storage block per way
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        way_array way_inst (
            .clk     (clk),
            .rst     (rst),
            .set_idx (set_idx),
            .wr      (way_wr[w]),
            .entry   (entries[w])
        );
    end

    way_match match_inst (
        .req         (cpu_req),
        .entries     (entries),
        .victim_way  (victim_way),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim      (victim),
        .read_word   (read_word),
        .merged_line (merged_line)
    );

    plru_tree plru_inst (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (set_idx),
        .victim_way (victim_way),
        .update     (plru_update),
        .used_way   (plru_way)
    );

endmodule

// ==== rtl/plru_tree.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module plru_tree
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  set_idx_t set_idx,
    output way_idx_t victim_way,
    input  logic     update,
    input  way_idx_t used_way
);

    plru_bits_t tree [`CACHE_SETS];
    plru_bits_t cur;
    plru_bits_t nxt;

    assign cur = tree[set_idx];

    // bit0 picks the half, bit1 or bit2 the way inside it
    always_comb begin
        if (cur[0]) begin
            victim_way = cur[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = cur[2] ? 2'd2 : 2'd3;
        end
    end

    // point the tree away from the used way
    always_comb begin
        nxt = cur;
        case (used_way)
            2'd0: begin
                nxt[0] = 1'b0;
                nxt[1] = 1'b0;
            end
            2'd1: begin
                nxt[0] = 1'b0;
                nxt[1] = 1'b1;
            end
            2'd2: begin
                nxt[0] = 1'b1;
                nxt[2] = 1'b0;
            end
            default: begin
                nxt[0] = 1'b1;
                nxt[2] = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (update) begin
            tree[set_idx] <= nxt;
        end
    end

endmodule

// ==== rtl/way_array.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module way_array
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  set_idx_t   set_idx,
    input  way_write_t wr,
    output way_entry_t entry
);

    // storage for one way, indexed by set
    line_t                  lines [`CACHE_SETS];
    tag_t                   tags  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid;
    logic [`CACHE_SETS-1:0] dirty;

    // read port registers
    logic  valid_q;
    logic  dirty_q;
    tag_t  tag_q;
    line_t line_q;

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr.we) begin
            valid[set_idx] <= wr.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            tags[set_idx]  <= wr.tag;
            dirty[set_idx] <= wr.dirty;
            // byte enables for the line
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (wr.mask[b]) begin
                    lines[set_idx][8*b +: 8] <= wr.line[8*b +: 8];
                end
            end
        end
    end

    // synchronous read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid[set_idx];
        end
    end

    always_ff @(posedge clk) begin
        dirty_q <= dirty[set_idx];
        tag_q   <= tags[set_idx];
        line_q  <= lines[set_idx];
    end

    assign entry = '{
        valid: valid_q,
        dirty: dirty_q,
        tag:   tag_q,
        line:  line_q
    };

endmodule

// ==== rtl/way_match.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module way_match
    import cache_pkg::*;
(
    input  cpu_req_t   req,
    input  way_entry_t entries [`CACHE_WAYS],
    input  way_idx_t   victim_way,
    output logic       hit,
    output way_idx_t   hit_way,
    output way_entry_t victim,
    output word_t      read_word,
    output line_t      merged_line
);

    logic [`CACHE_WAYS-1:0] way_hits;
    line_t                  hit_line;
    logic [`OFFSET_W-1:0]   offset;
    logic                   pending;

    assign offset  = req.addr.f.offset;
    assign pending = (req.rmask != '0) || (req.wmask != '0);

    // per-way tag compare
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hits[w] = entries[w].valid && (entries[w].tag == req.addr.f.tag);
        end
    end

    // lowest hitting way wins
    always_comb begin
        hit     = |way_hits;
        hit_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (way_hits[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit_line  = entries[hit_way].line;
    assign read_word = hit_line[8*offset +: `WORD_W];

    // write bytes land on top of the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < `WORD_W/8; b++) begin
            if (req.wmask[b]) begin
                merged_line[8*(offset + b) +: 8] = req.wdata[8*b +: 8];
            end
        end
    end

    assign victim = entries[victim_way];

    // a tag lives in at most one way of a set
    always_comb begin
        if (pending) begin
            assert final ($onehot0(way_hits))
                else $error("way_match: tag present in more than one way");
        end
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/way_array.sv
rtl/way_match.sv
rtl/plru_tree.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/tb_cache.sv

// ==== test/cache_stimulus.txt ====
# op addr mask wdata exp_rdata exp_mem_reads exp_mem_writes
# op is r or w; addr, mask and data in hex; counts in decimal
r 00001064 f 00000000 5a5a1064 1 0
r 00001064 f 00000000 5a5a1064 0 0
w 00001064 3 1234abcd 00000000 0 0
r 00001064 f 00000000 5a5aabcd 0 0
# fill set 3 with three more tags, then a fifth evicts the dirty line
r 00002068 f 00000000 5a5a2068 1 0
r 00003070 f 00000000 5a5a3070 1 0
r 0000407c f 00000000 5a5a407c 1 0
r 12345660 f 00000000 486e5660 1 1
r 00002068 f 00000000 5a5a2068 0 0
r 00003070 f 00000000 5a5a3070 0 0
r 0000407c f 00000000 5a5a407c 0 0
r 00001064 f 00000000 5a5aabcd 1 0
r 12345660 f 00000000 486e5660 1 0
# full word write, then push that line out again
w 12345660 f deadbeef 00000000 0 0
r 12345660 f 00000000 deadbeef 0 0
r 00002068 f 00000000 5a5a2068 1 0
r 00003070 f 00000000 5a5a3070 1 0
r 0000407c f 00000000 5a5a407c 1 0
r 00001064 f 00000000 5a5aabcd 1 1
r 12345660 f 00000000 deadbeef 1 0
# write miss in set 5
w 000000a8 c cafe0000 00000000 1 0
r 000000a8 f 00000000 cafe00a8 0 0

// ==== test/tb_cache.sv ====
`timescale 1ns/10ps
`include "cache_params.svh"

module tb_cache
    import cache_pkg::*;
();

    localparam int RESP_TIMEOUT = 50;
    localparam int HIT_EDGES    = 2;

    logic     clk = 1'b0;
    logic     rst;
    cpu_req_t cpu_req;
    word_t    cpu_rdata;
    logic     cpu_resp;
    mem_req_t mem_req;
    line_t    mem_rdata;
    logic     mem_resp;

    // backing store and the expected line contents as the processor wrote them
    line_t       mem_lines [logic [31:0]];
    line_t       ref_lines [logic [31:0]];
    logic [7:0]  lfsr_state = 8'd27;
    int          mem_reads;
    int          mem_writes;
    int          first_write;
    logic [31:0] op_line;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    cache_top cache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    always #10 clk = ~clk;

    function automatic line_t pattern_line(logic [31:0] base);
        line_t l;
        for (int i = 0; i < `LINE_BYTES / 4; i++) begin
            l[32*i +: 32] = (base + 32'(4 * i)) ^ 32'h5A5A0000;
        end
        return l;
    endfunction

    function automatic line_t expected_line(logic [31:0] base);
        if (ref_lines.exists(base)) begin
            return ref_lines[base];
        end else begin
            return pattern_line(base);
        end
    endfunction

    function automatic line_t stored_line(logic [31:0] base);
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end else begin
            return pattern_line(base);
        end
    endfunction

    // fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_delay(output int cycles);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[i]    = lfsr_state[0];
        end
        cycles = int'(bits) + 1;
    endtask

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_line(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR @ %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("ERR @ %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR @ %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one memory transaction, entered at the negedge that sees the strobe
    task automatic serve_memory();
        logic [31:0] addr;
        logic        is_write;
        line_t       wdata;
        int          delay;
        addr     = mem_req.addr;
        is_write = mem_req.write;
        wdata    = mem_req.wdata;
        if (first_write < 0) begin
            first_write = is_write ? 1 : 0;
        end
        if (is_write) begin
            mem_writes++;
            compare_word("write-back address offset", {27'b0, addr[4:0]}, '0);
            compare_line($sformatf("write-back line at %h", addr), wdata, expected_line(addr));
            mem_lines[addr] = wdata;
        end else begin
            mem_reads++;
            compare_word("refill address", addr, op_line);
        end
        take_delay(delay);
        repeat (delay) @(posedge clk);
        #1;
        compare_flag("memory strobe held", is_write ? mem_req.write : mem_req.read, 1'b1);
        mem_resp  = 1'b1;
        mem_rdata = is_write ? '0 : stored_line(addr);
        @(posedge clk);
        #1;
        mem_resp  = 1'b0;
        mem_rdata = '0;
    endtask

    always begin
        @(negedge clk);
        if (!rst && (mem_req.read || mem_req.write)) begin
            serve_memory();
        end
    end

    // entered 1 ns after a rising edge, leaves 1 ns after the edge that ends the response
    task automatic run_op(input int num, input byte op, input logic [31:0] addr,
                          input byte_mask_t mask, input word_t wdata, input word_t exp_rdata,
                          input int exp_reads, input int exp_writes, output logic timed_out);
        int    errors_before;
        int    edges;
        int    off;
        logic  seen;
        line_t l;
        string result;
        errors_before = error_count;
        mem_reads     = 0;
        mem_writes    = 0;
        first_write   = -1;
        op_line       = {addr[31:5], 5'b0};
        off           = int'(addr[4:0]);
        cpu_req.addr.raw = addr;
        cpu_req.rmask    = (op == "r") ? mask : '0;
        cpu_req.wmask    = (op == "w") ? mask : '0;
        cpu_req.wdata    = wdata;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < RESP_TIMEOUT) begin
            @(negedge clk);
            edges++;
            seen = cpu_resp;
        end
        timed_out = !seen;
        if (timed_out) begin
            $display("op %0d: no cpu_resp within %0d cycles", num, RESP_TIMEOUT);
            tests_failed++;
        end else begin
            if (op == "r") begin
                compare_word("read data", cpu_rdata, exp_rdata);
            end
            compare_count("memory reads", mem_reads, exp_reads);
            compare_count("memory writes", mem_writes, exp_writes);
            if (exp_writes > 0) begin
                compare_count("write-back before refill", first_write, 1);
            end
            // first negedge comes before the edge that samples the request
            if (exp_reads == 0 && exp_writes == 0) begin
                compare_count("hit latency in edges", edges - 1, HIT_EDGES);
            end
            if (op == "w") begin
                l = expected_line(op_line);
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) begin
                        l[8*(off + b) +: 8] = wdata[8*b +: 8];
                    end
                end
                ref_lines[op_line] = l;
            end
            result = "ok";
            if (error_count != errors_before) begin
                result = "failed";
                tests_failed++;
            end else begin
                tests_passed++;
            end
            $display("op %0d %c %h: %s", num, op, addr, result);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        int          num;
        int          bad_lines;
        int          errors_before;
        string       line;
        byte         op;
        logic [31:0] addr;
        byte_mask_t  mask;
        word_t       wdata;
        word_t       exp_rdata;
        int          exp_reads;
        int          exp_writes;
        logic        timed_out;
        num       = 0;
        bad_lines = 0;
        timed_out = 1'b0;
        rst       = 1'b1;
        cpu_req   = '0;
        mem_resp  = 1'b0;
        mem_rdata = '0;

        // outputs quiet in reset and in the first cycle after it
        errors_before = error_count;
        for (int c = 0; c < 6; c++) begin
            @(posedge clk);
            if (c == 4) begin
                #1;
                rst = 1'b0;
            end
            @(negedge clk);
            compare_flag("cpu_resp", cpu_resp, 1'b0);
            compare_flag("memory read strobe", mem_req.read, 1'b0);
            compare_flag("memory write strobe", mem_req.write, 1'b0);
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("reset: ok");
        end else begin
            tests_failed++;
            $display("reset: failed");
        end
        @(posedge clk);
        #1;

        fd = $fopen("test/cache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/cache_stimulus.txt");
            bad_lines++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%c %h %h %h %h %d %d", op, addr, mask, wdata,
                                 exp_rdata, exp_reads, exp_writes);
                if (fields != 7) begin
                    $display("stimulus line not understood: %s", line);
                    bad_lines++;
                    continue;
                end
                num++;
                run_op(num, op, addr, mask, wdata, exp_rdata, exp_reads, exp_writes, timed_out);
            end
            $fclose(fd);
        end
        cpu_req = '0;

        $display("tests passed %0d, failed %0d, value errors %0d", tests_passed, tests_failed,
                 error_count);
        if (!timed_out && bad_lines == 0 && num > 0 && tests_failed == 0 && error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
